//--- hw/axil_channel_fsm.sv
module axil_channel_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [regblk_pkg::DATA_W-1:0] awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [regblk_pkg::DATA_W-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [7:0]                    error_code,
    output logic                          write_en,
    output logic [regblk_pkg::OFFS_W-1:0] write_offset,
    output logic [regblk_pkg::OFFS_W-1:0] read_offset,
    output logic [7:0]                    write_err_code
);

    import regblk_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_DATA,
        WRITE_RESP,
        READ_DATA
    } chan_state_e;

    chan_state_e state;
    chan_state_e state_next;

    logic aw_hs;
    logic ar_hs;

    // Ready and valid straight from the state
    assign awready = (state == IDLE);
    assign arready = (state == IDLE) && !awvalid;   // Writes win a tie
    assign wready  = (state == WRITE_DATA);
    assign bvalid  = (state == WRITE_RESP);
    assign rvalid  = (state == READ_DATA);

    assign aw_hs    = awvalid && awready;
    assign ar_hs    = arvalid && arready;
    assign write_en = wvalid && wready;             // High for the W handshake cycle

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_next = WRITE_DATA;
                end else if (ar_hs) begin
                    state_next = READ_DATA;
                end
            end
            WRITE_DATA: begin
                if (write_en) begin
                    state_next = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_next = IDLE;
                end
            end
            READ_DATA: begin
                if (rready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Address and error code captured at the address handshakes
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            write_offset   <= awaddr[OFFS_W-1:0];
            write_err_code <= error_code;     // Judged later against the CRC code
        end
        if (ar_hs) begin
            read_offset <= araddr[OFFS_W-1:0];
        end
    end

    a_one_response: assert property (@(posedge clk) disable iff (rst)
        !(bvalid && rvalid));

    // Read data is offered until the master takes it
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid);

endmodule

//--- hw/reg_read_mux.sv
module reg_read_mux (
    input  logic [regblk_pkg::OFFS_W-1:0] read_offset,
    input  logic                          control_bit,
    input  regblk_pkg::config_word_u      config_word,
    input  logic [3:0]                    debug_mode,
    input  logic [3:0]                    led,
    input  logic                          bridge_busy,
    input  logic [7:0]                    error_code,
    input  logic [15:0]                   tx_count,
    input  logic [15:0]                   rx_count,
    input  logic [7:0]                    fifo_status,
    output logic [regblk_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                    rresp
);

    import regblk_pkg::*;

    logic [OFFS_W-1:0] aligned;
    logic              read_ok;
    logic [DATA_W-1:0] status_word;

    assign aligned = {read_offset[OFFS_W-1:2], 2'b00};

    // Reads must be whole words
    assign read_ok = reg_mapped(aligned) && (read_offset[1:0] == 2'b00);

    always_comb begin
        status_word                            = '0;
        status_word[STAT_BUSY_BIT]             = bridge_busy;
        status_word[STAT_ERR_LSB +: 8]         = error_code;     // Live, not latched
    end

    always_comb begin
        rdata = '0;
        rresp = RESP_OKAY;
        if (!read_ok) begin
            rresp = RESP_SLVERR;
        end else begin
            case (aligned)
                REG_CONTROL: begin
                    rdata[CTRL_EN_BIT] = control_bit;   // Strobe bit always reads 0
                end
                REG_STATUS: begin
                    rdata = status_word;
                end
                REG_CONFIG: begin
                    rdata = config_word;
                end
                REG_DEBUG: begin
                    rdata = DATA_W'(debug_mode);
                end
                REG_TX_COUNT: begin
                    rdata = DATA_W'(tx_count);
                end
                REG_RX_COUNT: begin
                    rdata = DATA_W'(rx_count);
                end
                REG_FIFO_STAT: begin
                    rdata = DATA_W'(fifo_status);
                end
                REG_VERSION: begin
                    rdata = VERSION_WORD;
                end
                REG_LED: begin
                    rdata = DATA_W'(led);
                end
                default: begin
                    rdata = '0;
                end
            endcase
        end
    end

endmodule

//--- hw/reg_write_unit.sv
module reg_write_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          soft_reset_request,
    input  logic                          write_en,
    input  logic [regblk_pkg::OFFS_W-1:0] write_offset,
    input  logic [regblk_pkg::DATA_W-1:0] wdata,
    input  logic [regblk_pkg::STRB_W-1:0] wstrb,
    input  logic [7:0]                    write_err_code,
    output logic                          control_bit,
    output regblk_pkg::config_word_u      config_word,
    output logic [3:0]                    debug_mode,
    output logic [3:0]                    led,
    output logic                          bridge_reset_stats,
    output logic [1:0]                    bresp
);

    import regblk_pkg::*;

    logic [OFFS_W-1:0] aligned;
    logic              mapped;
    logic              strb_legal;
    logic [1:0]        strb_lsb;        // Address bits the pattern requires
    logic              strb_fits;
    logic              write_ok;
    logic [DATA_W-1:0] lane_mask;

    logic              sel_ctrl;
    logic              sel_cfg;
    logic              sel_dbg;
    logic              sel_led;

    logic [DATA_W-1:0] ctrl_merged;
    logic [DATA_W-1:0] dbg_merged;
    logic [DATA_W-1:0] led_merged;
    config_word_u      cfg_next;

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] cur,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [DATA_W-1:0] mask);
        return (cur & ~mask) | (data & mask);
    endfunction

    assign aligned = {write_offset[OFFS_W-1:2], 2'b00};
    assign mapped  = reg_mapped(aligned);

    // Strobe pattern check and its address requirement
    always_comb begin
        strb_legal = 1'b1;
        strb_lsb   = 2'b00;
        case (wstrb)
            STRB_BYTE:      strb_lsb = STRB_BYTE_LSB;
            STRB_LOW_HALF:  strb_lsb = STRB_LOW_HALF_LSB;
            STRB_HIGH_HALF: strb_lsb = STRB_HIGH_HALF_LSB;
            STRB_WORD:      strb_lsb = STRB_WORD_LSB;
            default:        strb_legal = 1'b0;
        endcase
    end

    assign strb_fits = strb_legal && (write_offset[1:0] == strb_lsb);
    assign write_ok  = mapped && strb_fits;

    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            lane_mask[8*i +: 8] = {8{wstrb[i]}};
        end
    end

    // Read-only words match none of these and take no effect
    assign sel_ctrl = write_ok && (aligned == REG_CONTROL);
    assign sel_cfg  = write_ok && (aligned == REG_CONFIG);
    assign sel_dbg  = write_ok && (aligned == REG_DEBUG);
    assign sel_led  = write_ok && (aligned == REG_LED);

    // Merged words, reserved bits dropped when stored
    always_comb begin
        ctrl_merged = merge_lanes(DATA_W'(control_bit), wdata, lane_mask);
        dbg_merged  = merge_lanes(DATA_W'(debug_mode), wdata, lane_mask);
        led_merged  = merge_lanes(DATA_W'(led), wdata, lane_mask);
        cfg_next    = merge_lanes(config_word, wdata, lane_mask);
        cfg_next.baud.rsvd = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            control_bit        <= 1'b0;
            config_word        <= CONFIG_RESET;
            debug_mode         <= '0;
            led                <= '0;
            bridge_reset_stats <= 1'b0;
            bresp              <= RESP_OKAY;
        end else begin
            bridge_reset_stats <= write_en && sel_ctrl && wstrb[0]
                                  && wdata[CTRL_RST_STATS_BIT];

            // Soft reset overrides a write to the same register
            if (soft_reset_request) begin
                control_bit <= 1'b0;
                debug_mode  <= '0;
            end else if (write_en) begin
                if (sel_ctrl) begin
                    control_bit <= ctrl_merged[CTRL_EN_BIT];
                end
                if (sel_dbg) begin
                    debug_mode <= dbg_merged[3:0];
                end
            end

            if (write_en) begin
                if (sel_cfg) begin
                    config_word <= cfg_next;
                end
                if (sel_led) begin
                    led <= led_merged[3:0];
                end
                if (!write_ok) begin
                    bresp <= RESP_SLVERR;
                end else if (write_err_code == STATUS_CRC_ERR) begin
                    bresp <= RESP_SLVERR;   // Write lands but is reported as failed
                end else begin
                    bresp <= RESP_OKAY;
                end
            end
        end
    end

    // Relies on the channel FSM never granting two W handshakes back to back
    a_stats_pulse: assert property (@(posedge clk) disable iff (rst)
        bridge_reset_stats |=> !bridge_reset_stats);

endmodule

//--- hw/regblk_pkg.sv
package regblk_pkg;

    // Bus geometry
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int OFFS_W = 12;                 // Low address bits that select a register

    // Register map, byte offsets
    localparam logic [OFFS_W-1:0] REG_CONTROL   = 12'h000;
    localparam logic [OFFS_W-1:0] REG_STATUS    = 12'h004;   // RO
    localparam logic [OFFS_W-1:0] REG_CONFIG    = 12'h008;
    localparam logic [OFFS_W-1:0] REG_DEBUG     = 12'h00C;
    localparam logic [OFFS_W-1:0] REG_TX_COUNT  = 12'h010;   // RO
    localparam logic [OFFS_W-1:0] REG_RX_COUNT  = 12'h014;   // RO
    localparam logic [OFFS_W-1:0] REG_FIFO_STAT = 12'h018;   // RO
    localparam logic [OFFS_W-1:0] REG_VERSION   = 12'h01C;   // RO
    localparam logic [OFFS_W-1:0] REG_LED       = 12'h044;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Bridge error code that turns a legal write into SLVERR
    localparam logic [7:0] STATUS_CRC_ERR = 8'h01;

    // Reset and constant words
    localparam logic [DATA_W-1:0] CONFIG_RESET = 32'h0000_043D;   // Divisor 1085
    localparam logic [DATA_W-1:0] VERSION_WORD = 32'h0001_0000;

    // Field positions
    localparam int CTRL_EN_BIT        = 0;    // Stored control bit
    localparam int CTRL_RST_STATS_BIT = 1;    // Self-clearing strobe, never stored
    localparam int STAT_BUSY_BIT      = 0;
    localparam int STAT_ERR_LSB       = 1;    // Error code occupies bits 8:1

    // Legal strobe patterns and the address bits 1:0 each one needs
    localparam logic [STRB_W-1:0] STRB_BYTE          = 4'b0001;
    localparam logic [1:0]        STRB_BYTE_LSB      = 2'b00;
    localparam logic [STRB_W-1:0] STRB_LOW_HALF      = 4'b0011;
    localparam logic [1:0]        STRB_LOW_HALF_LSB  = 2'b00;
    localparam logic [STRB_W-1:0] STRB_HIGH_HALF     = 4'b1100;
    localparam logic [1:0]        STRB_HIGH_HALF_LSB = 2'b10;
    localparam logic [STRB_W-1:0] STRB_WORD          = 4'b1111;
    localparam logic [1:0]        STRB_WORD_LSB      = 2'b00;

    // Configuration register, seen as baud divisor or as timeout byte
    typedef union packed {
        struct packed {
            logic [15:0] rsvd;
            logic [15:0] baud_div;
        } baud;
        struct packed {
            logic [15:0] rsvd;
            logic [7:0]  timeout;
            logic [7:0]  low_byte;      // Low half of the divisor
        } tmo;
    } config_word_u;

    // True when a word-aligned offset hits a mapped register
    function automatic logic reg_mapped(input logic [OFFS_W-1:0] aligned);
        case (aligned)
            REG_CONTROL, REG_STATUS, REG_CONFIG, REG_DEBUG,
            REG_TX_COUNT, REG_RX_COUNT, REG_FIFO_STAT, REG_VERSION,
            REG_LED: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

//--- hw/uart_reg_block.sv
module uart_reg_block (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          soft_reset_request,

    // AXI4-Lite slave
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [regblk_pkg::DATA_W-1:0] awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [regblk_pkg::DATA_W-1:0] wdata,
    input  logic [regblk_pkg::STRB_W-1:0] wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [regblk_pkg::DATA_W-1:0] araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [regblk_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                    rresp,

    // Bridge status
    input  logic                          bridge_busy,
    input  logic [7:0]                    error_code,
    input  logic [15:0]                   tx_count,
    input  logic [15:0]                   rx_count,
    input  logic [7:0]                    fifo_status,

    // Bridge control
    output logic                          bridge_reset_stats,
    output logic [15:0]                   baud_div_config,
    output logic [7:0]                    timeout_config,
    output logic [3:0]                    debug_mode,
    output logic [3:0]                    test_led
);

    import regblk_pkg::*;

    logic              write_en;
    logic [OFFS_W-1:0] write_offset;
    logic [OFFS_W-1:0] read_offset;
    logic [7:0]        write_err_code;
    logic              control_bit;
    config_word_u      config_word;

    axil_channel_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bready         (bready),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .error_code     (error_code),
        .write_en       (write_en),
        .write_offset   (write_offset),
        .read_offset    (read_offset),
        .write_err_code (write_err_code)
    );

    reg_write_unit u_write (
        .clk                (clk),
        .rst                (rst),
        .soft_reset_request (soft_reset_request),
        .write_en           (write_en),
        .write_offset       (write_offset),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .write_err_code     (write_err_code),
        .control_bit        (control_bit),
        .config_word        (config_word),
        .debug_mode         (debug_mode),
        .led                (test_led),
        .bridge_reset_stats (bridge_reset_stats),
        .bresp              (bresp)
    );

    reg_read_mux u_read (
        .read_offset (read_offset),
        .control_bit (control_bit),
        .config_word (config_word),
        .debug_mode  (debug_mode),
        .led         (test_led),
        .bridge_busy (bridge_busy),
        .error_code  (error_code),
        .tx_count    (tx_count),
        .rx_count    (rx_count),
        .fifo_status (fifo_status),
        .rdata       (rdata),
        .rresp       (rresp)
    );

    // Both fields come from the one configuration word
    assign baud_div_config = config_word.baud.baud_div;
    assign timeout_config  = config_word.tmo.timeout;   // Overlaps divisor bits 15:8

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_uart_reg_block

out=$(./obj_dir/Vtb_uart_reg_block)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

//--- src.f
+incdir+tests
hw/regblk_pkg.sv
hw/axil_channel_fsm.sv
hw/reg_write_unit.sv
hw/reg_read_mux.sv
hw/uart_reg_block.sv
tests/tb_uart_reg_block.sv

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int fail_count  = 0;
int check_count = 0;    // Checks armed by the bus tasks

// Read channel, compared at the R handshake
a_rdata: assert property (@(posedge clk) disable iff (rst)
    rvalid && rready && rchk |-> rdata == exp_rdata)
else begin
    fail_count++;
    $display("CHECK FAILED rdata: got %h expected %h", $sampled(rdata), $sampled(exp_rdata));
end

a_rresp: assert property (@(posedge clk) disable iff (rst)
    rvalid && rready && rchk |-> rresp == exp_rresp)
else begin
    fail_count++;
    $display("CHECK FAILED rresp: got %h expected %h", $sampled(rresp), $sampled(exp_rresp));
end

a_bresp: assert property (@(posedge clk) disable iff (rst)
    bvalid && bready && bchk |-> bresp == exp_bresp)
else begin
    fail_count++;
    $display("CHECK FAILED bresp: got %h expected %h", $sampled(bresp), $sampled(exp_bresp));
end

// Bridge control outputs, compared for one cycle when ochk is set
a_baud: assert property (@(posedge clk) disable iff (rst)
    ochk |-> baud_div_config == exp_baud)
else begin
    fail_count++;
    $display("CHECK FAILED baud_div_config: got %h expected %h",
             $sampled(baud_div_config), $sampled(exp_baud));
end

a_timeout: assert property (@(posedge clk) disable iff (rst)
    ochk |-> timeout_config == exp_timeout)
else begin
    fail_count++;
    $display("CHECK FAILED timeout_config: got %h expected %h",
             $sampled(timeout_config), $sampled(exp_timeout));
end

a_debug: assert property (@(posedge clk) disable iff (rst)
    ochk |-> debug_mode == exp_debug)
else begin
    fail_count++;
    $display("CHECK FAILED debug_mode: got %h expected %h",
             $sampled(debug_mode), $sampled(exp_debug));
end

a_led: assert property (@(posedge clk) disable iff (rst)
    ochk |-> test_led == exp_led)
else begin
    fail_count++;
    $display("CHECK FAILED test_led: got %h expected %h", $sampled(test_led), $sampled(exp_led));
end

// Pulse one cycle after the armed W handshake, and never otherwise
a_stats_pulse: assert property (@(posedge clk) disable iff (rst)
    wvalid && wready && stats_armed |=> bridge_reset_stats)
else begin
    fail_count++;
    $display("CHECK FAILED bridge_reset_stats: got %h expected %h", 1'b0, 1'b1);
end

a_stats_stray: assert property (@(posedge clk) disable iff (rst)
    bridge_reset_stats |-> $past(wvalid && wready && stats_armed))
else begin
    fail_count++;
    $display("CHECK FAILED bridge_reset_stats: got %h expected %h", 1'b1, 1'b0);
end

`endif

//--- tests/tb_uart_reg_block.sv
module tb_uart_reg_block;

    import regblk_pkg::*;

    logic        clk                = 1'b0;
    logic        rst                = 1'b1;
    logic        soft_reset_request = 1'b0;
    logic        awvalid            = 1'b0;
    logic [31:0] awaddr             = '0;
    logic        wvalid             = 1'b0;
    logic [31:0] wdata              = '0;
    logic [3:0]  wstrb              = '0;
    logic        bready             = 1'b0;
    logic        arvalid            = 1'b0;
    logic [31:0] araddr             = '0;
    logic        rready             = 1'b0;
    logic        bridge_busy        = 1'b0;
    logic [7:0]  error_code         = '0;
    logic [15:0] tx_count           = '0;
    logic [15:0] rx_count           = '0;
    logic [7:0]  fifo_status        = '0;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        bridge_reset_stats;
    logic [15:0] baud_div_config;
    logic [7:0]  timeout_config;
    logic [3:0]  debug_mode;
    logic [3:0]  test_led;

    // Expected values and the flags that arm each check
    logic        rchk        = 1'b0;
    logic        bchk        = 1'b0;
    logic        ochk        = 1'b0;
    logic        stats_armed = 1'b0;
    logic [31:0] exp_rdata   = '0;
    logic [1:0]  exp_rresp   = '0;
    logic [1:0]  exp_bresp   = '0;
    logic [15:0] exp_baud    = '0;
    logic [7:0]  exp_timeout = '0;
    logic [3:0]  exp_debug   = '0;
    logic [3:0]  exp_led     = '0;

    int seed         = 32'hc83b_32d7;
    bit timed_out    = 1'b0;
    int test_count   = 0;
    int fails_before = 0;

    always #4 clk = ~clk;

    uart_reg_block UUT (.*);

    `include "tb_checks.svh"

    function automatic int ready_delay();
        int r;
        r = $random(seed);
        return r & 3;    // 0 to 3 idle cycles before bready or rready
    endfunction

    // Level is sampled mid-cycle, the handshake lands on the next rising edge
    task automatic wait_for(input string name);
        int   n;
        logic hs;
        n  = 0;
        hs = 1'b0;
        while (!hs && !timed_out) begin
            @(negedge clk);
            case (name)
                "awready": hs = awready;
                "wready":  hs = wready;
                "bvalid":  hs = bvalid;
                "arready": hs = arready;
                default:   hs = rvalid;
            endcase
            @(posedge clk);
            n++;
            if (!hs && n >= 50) begin
                $display("Timeout: no %s within 50 cycles", name);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] resp);
        awaddr    <= addr;
        awvalid   <= 1'b1;
        wdata     <= data;
        wstrb     <= strb;
        wvalid    <= 1'b1;
        exp_bresp <= resp;
        bchk      <= 1'b1;
        check_count++;
        wait_for("awready");
        awvalid <= 1'b0;
        wait_for("wready");
        wvalid <= 1'b0;
        repeat (ready_delay()) @(posedge clk);
        bready <= 1'b1;
        wait_for("bvalid");
        bready <= 1'b0;
        bchk   <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
        araddr    <= addr;
        arvalid   <= 1'b1;
        exp_rdata <= data;
        exp_rresp <= resp;
        rchk      <= 1'b1;
        check_count += 2;
        wait_for("arready");
        arvalid <= 1'b0;
        repeat (ready_delay()) @(posedge clk);
        rready <= 1'b1;
        wait_for("rvalid");
        rready <= 1'b0;
        rchk   <= 1'b0;
    endtask

    task automatic expect_outputs(input logic [15:0] baud, input logic [7:0] tmo,
                                  input logic [3:0] dbg, input logic [3:0] led);
        exp_baud    <= baud;
        exp_timeout <= tmo;
        exp_debug   <= dbg;
        exp_led     <= led;
        ochk        <= 1'b1;
        check_count += 4;
        @(posedge clk);
        ochk <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        test_count++;
        if (fail_count == fails_before && !timed_out) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: errors found", test_count, name);
        end
        fails_before = fail_count;
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        read_word(REG_CONFIG, 32'h0000_043D, RESP_OKAY);
        read_word(REG_VERSION, 32'h0001_0000, RESP_OKAY);
        read_word(REG_CONTROL, 32'h0, RESP_OKAY);
        read_word(REG_DEBUG, 32'h0, RESP_OKAY);
        read_word(REG_LED, 32'h0, RESP_OKAY);
        expect_outputs(16'h043D, 8'h04, 4'h0, 4'h0);
        end_test("reset values");

        write_word(REG_CONFIG, 32'hA5A5_1234, 4'b1111, RESP_OKAY);
        read_word(REG_CONFIG, 32'h0000_1234, RESP_OKAY);    // Upper half is reserved
        write_word(REG_CONFIG, 32'hFFFF_5678, 4'b0011, RESP_OKAY);
        write_word(REG_CONFIG, 32'hFFFF_FFAB, 4'b0001, RESP_OKAY);
        write_word(REG_CONFIG + 2, 32'h9999_0000, 4'b1100, RESP_OKAY);
        read_word(REG_CONFIG, 32'h0000_56AB, RESP_OKAY);
        write_word(REG_DEBUG, 32'hFFFF_FFF6, 4'b1111, RESP_OKAY);
        read_word(REG_DEBUG, 32'h0000_0006, RESP_OKAY);
        write_word(REG_DEBUG, 32'h0000_0009, 4'b0011, RESP_OKAY);
        write_word(REG_DEBUG, 32'h0000_0003, 4'b0001, RESP_OKAY);
        write_word(REG_DEBUG + 2, 32'hFFFF_0000, 4'b1100, RESP_OKAY);
        read_word(REG_DEBUG, 32'h0000_0003, RESP_OKAY);
        write_word(REG_LED, 32'hFFFF_FFFA, 4'b1111, RESP_OKAY);
        read_word(REG_LED, 32'h0000_000A, RESP_OKAY);
        expect_outputs(16'h56AB, 8'h56, 4'h3, 4'hA);
        end_test("strobe merges");

        write_word(32'h0000_0020, 32'hFFFF_FFFF, 4'b1111, RESP_SLVERR);   // Dropped register
        write_word(32'h0000_0100, 32'hFFFF_FFFF, 4'b1111, RESP_SLVERR);
        write_word(REG_CONFIG, 32'h0000_FFFF, 4'b0110, RESP_SLVERR);
        write_word(REG_CONFIG + 2, 32'h0000_FFFF, 4'b1111, RESP_SLVERR);
        read_word(32'h0000_0030, 32'h0, RESP_SLVERR);
        read_word(REG_CONFIG + 2, 32'h0, RESP_SLVERR);
        read_word(REG_CONFIG, 32'h0000_56AB, RESP_OKAY);
        read_word(REG_LED, 32'h0000_000A, RESP_OKAY);
        expect_outputs(16'h56AB, 8'h56, 4'h3, 4'hA);
        end_test("illegal accesses");

        stats_armed <= 1'b1;
        write_word(REG_CONTROL, 32'h0000_0003, 4'b0001, RESP_OKAY);
        stats_armed <= 1'b0;
        read_word(REG_CONTROL, 32'h0000_0001, RESP_OKAY);
        end_test("reset-stats strobe");

        r1 = $random(seed);
        r2 = $random(seed);
        bridge_busy <= r1[0];
        error_code  <= r1[15:8];
        fifo_status <= r1[23:16];
        tx_count    <= r2[15:0];
        rx_count    <= r2[31:16];
        read_word(REG_STATUS, {23'h0, r1[15:8], r1[0]}, RESP_OKAY);
        read_word(REG_TX_COUNT, {16'h0, r2[15:0]}, RESP_OKAY);
        read_word(REG_RX_COUNT, {16'h0, r2[31:16]}, RESP_OKAY);
        read_word(REG_FIFO_STAT, {24'h0, r1[23:16]}, RESP_OKAY);
        error_code <= STATUS_CRC_ERR;
        write_word(REG_LED, 32'h0000_0005, 4'b0001, RESP_SLVERR);   // Lands despite SLVERR
        error_code <= 8'h00;
        read_word(REG_LED, 32'h0000_0005, RESP_OKAY);
        end_test("status and CRC error");

        soft_reset_request <= 1'b1;
        @(posedge clk);
        soft_reset_request <= 1'b0;
        read_word(REG_CONTROL, 32'h0, RESP_OKAY);
        read_word(REG_DEBUG, 32'h0, RESP_OKAY);
        read_word(REG_CONFIG, 32'h0000_56AB, RESP_OKAY);
        read_word(REG_LED, 32'h0000_0005, RESP_OKAY);
        expect_outputs(16'h56AB, 8'h56, 4'h0, 4'h5);
        end_test("soft reset");

        $display("Tests: %0d  checks: %0d  failures: %0d", test_count, check_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
